// ==== verilog.f ====
+incdir+include
src/obi_integrity_pkg.sv
src/achk_gen.sv
src/req_tracker.sv
src/resp_capture.sv
src/rchk_check.sv
src/alert_ctrl.sv
src/obi_integrity_top.sv
sim/tb_obi_integrity.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the integrity unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE="${BUILD_DIR}/sim.log"

verilator --binary --timing --assert -j 0 \
  --top-module tb_obi_integrity \
  -Mdir "${BUILD_DIR}" \
  -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./${BUILD_DIR}/Vtb_obi_integrity" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
  echo "Simulation exited with status ${sim_status}"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "${LOG_FILE}"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== include/obi_ref_model.svh ====
/*
  Reference model for the integrity testbench. Tracks the request held on
  the bus, the queue of granted requests and the responses still expected
  at the outputs. Included inside the testbench module.
*/
`ifndef OBI_REF_MODEL_SVH
`define OBI_REF_MODEL_SVH

// Request held on the bus
logic                        m_req;
obi_integrity_pkg::addr_t    m_addr;
logic                        m_we;
obi_integrity_pkg::be_t      m_be;
obi_integrity_pkg::data_t    m_wdata;
obi_integrity_pkg::prot_t    m_prot;
obi_integrity_pkg::memtype_t m_memtype;
logic                        m_dbg;
logic                        m_integrity;

// Granted requests waiting for rvalid
logic q_store[$];
logic q_integrity[$];
logic q_gnt_fault[$];

// Responses on their way to the outputs
int                       exp_due[$];
obi_integrity_pkg::data_t exp_rdata[$];
logic                     exp_err[$];
logic                     exp_ie[$];

// Byte parities of data and address, inverted control parities
function automatic obi_integrity_pkg::achk_t achk_expected(
  input obi_integrity_pkg::addr_t    addr,
  input logic                        we,
  input obi_integrity_pkg::be_t      be,
  input obi_integrity_pkg::data_t    wdata,
  input obi_integrity_pkg::prot_t    prot,
  input obi_integrity_pkg::memtype_t memtype,
  input logic                        dbg
);
  obi_integrity_pkg::achk_t r;
  r = '0;
  for (int i = 0; i < 4; i++) begin
    r[9 + i] = ^wdata[8*i +: 8];
    r[i] = ^addr[8*i +: 8];
  end
  r[8] = ~dbg;
  // Bits 7 and 6 cover atop and manager ID, both zero
  r[5] = ~((^be) ^ we);
  r[4] = ~((^prot) ^ (^memtype));
  return r;
endfunction

// Top bit follows err since exokay is never set
function automatic obi_integrity_pkg::rchk_t rchk_expected(
  input logic                     err,
  input obi_integrity_pkg::data_t rdata
);
  obi_integrity_pkg::rchk_t r;
  r[4] = err;
  for (int i = 0; i < 4; i++) begin
    r[i] = ^rdata[8*i +: 8];
  end
  return r;
endfunction

// Mask holds the rchk bits that were flipped on the bus
function automatic logic integrity_err_expected(
  input logic                     store,
  input logic                     integrity,
  input logic                     enable,
  input obi_integrity_pkg::rchk_t mask,
  input logic                     par_fault
);
  logic mismatch;
  mismatch = store ? mask[4] : (mask != 5'd0);
  return (mismatch && enable && integrity) || par_fault;
endfunction

task automatic push_expected(
  input int                       due,
  input obi_integrity_pkg::data_t rdata,
  input logic                     err,
  input logic                     ie
);
  exp_due.push_back(due);
  exp_rdata.push_back(rdata);
  exp_err.push_back(err);
  exp_ie.push_back(ie);
endtask

task automatic drop_expected();
  void'(exp_due.pop_front());
  void'(exp_rdata.pop_front());
  void'(exp_err.pop_front());
  void'(exp_ie.pop_front());
endtask

task automatic clear_model();
  m_req = 1'b0;
  q_store.delete();
  q_integrity.delete();
  q_gnt_fault.delete();
  exp_due.delete();
  exp_rdata.delete();
  exp_err.delete();
  exp_ie.delete();
endtask

`endif

// ==== sim/tb_obi_integrity.sv ====
/*
  Testbench for the data bus integrity unit. Drives random requests, grants
  and in-order responses with injected checksum and parity faults over four
  phases, and checks the DUT against the included reference model.
*/
`timescale 1ns/10ps

module tb_obi_integrity;

  localparam int NUM_PHASES = 4;
  localparam int PHASE_CYCLES = 400;
  localparam int RESET_CYCLES = 3;
  localparam int DRAIN_CYCLES = 30;
  // Whole run plus one spare phase
  localparam int TIMEOUT_CYCLES = NUM_PHASES * (PHASE_CYCLES + RESET_CYCLES) + PHASE_CYCLES;

  logic                        clk_i;
  logic                        rst_n;
  logic                        integrity_enable;
  logic                        core_req;
  obi_integrity_pkg::addr_t    core_addr;
  logic                        core_we;
  obi_integrity_pkg::be_t      core_be;
  obi_integrity_pkg::data_t    core_wdata;
  obi_integrity_pkg::prot_t    core_prot;
  obi_integrity_pkg::memtype_t core_memtype;
  logic                        core_dbg;
  logic                        core_integrity;
  logic                        obi_gnt;
  logic                        obi_gntpar;
  logic                        obi_rvalid;
  logic                        obi_rvalidpar;
  obi_integrity_pkg::data_t    obi_rdata;
  logic                        obi_err;
  obi_integrity_pkg::rchk_t    obi_rchk;
  logic                        obi_req;
  logic                        obi_reqpar;
  obi_integrity_pkg::addr_t    obi_addr;
  logic                        obi_we;
  obi_integrity_pkg::be_t      obi_be;
  obi_integrity_pkg::data_t    obi_wdata;
  obi_integrity_pkg::prot_t    obi_prot;
  obi_integrity_pkg::memtype_t obi_memtype;
  logic                        obi_dbg;
  obi_integrity_pkg::achk_t    obi_achk;
  logic                        resp_valid;
  obi_integrity_pkg::data_t    resp_rdata;
  logic                        resp_err;
  logic                        resp_integrity_err;
  logic                        alert_major;

  integer seed;
  int     cycle;
  int     total_cycles = 0;
  int     value_errors;
  int     other_errors;
  string  test_name;
  logic   fault_seen;
  int     alert_deadline;
  // Fault rates as one in N, zero for none
  int     rchk_rate;
  int     rvp_rate;
  int     gp_rate;

  `include "obi_ref_model.svh"

  obi_integrity_top u_dut (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    total_cycles <= total_cycles + 1;
    if (total_cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not reach its end", total_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic one_in(input int n);
    return ($unsigned($random(seed)) % n) == 0;
  endfunction

  task automatic achk_check(input string name, input obi_integrity_pkg::achk_t exp_val,
                            input obi_integrity_pkg::achk_t act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h at cycle %0d",
               test_name, name, exp_val, act_val, cycle);
    end
  endtask

  task automatic data_check(input string name, input obi_integrity_pkg::data_t exp_val,
                            input obi_integrity_pkg::data_t act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h at cycle %0d",
               test_name, name, exp_val, act_val, cycle);
    end
  endtask

  task automatic be_check(input string name, input obi_integrity_pkg::be_t exp_val,
                          input obi_integrity_pkg::be_t act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h at cycle %0d",
               test_name, name, exp_val, act_val, cycle);
    end
  endtask

  task automatic prot_check(input string name, input obi_integrity_pkg::prot_t exp_val,
                            input obi_integrity_pkg::prot_t act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h at cycle %0d",
               test_name, name, exp_val, act_val, cycle);
    end
  endtask

  task automatic memtype_check(input string name, input obi_integrity_pkg::memtype_t exp_val,
                               input obi_integrity_pkg::memtype_t act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h at cycle %0d",
               test_name, name, exp_val, act_val, cycle);
    end
  endtask

  task automatic bit_check(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b at cycle %0d",
               test_name, name, exp_val, act_val, cycle);
    end
  endtask

  // Alert must follow within four cycles of the first fault
  task automatic note_fault();
    if (!fault_seen) begin
      fault_seen = 1'b1;
      alert_deadline = cycle + 4;
    end
  endtask

  task automatic drive_idle();
    core_req = 1'b0;
    core_addr = '0;
    core_we = 1'b0;
    core_be = '0;
    core_wdata = '0;
    core_prot = '0;
    core_memtype = '0;
    core_dbg = 1'b0;
    core_integrity = 1'b0;
    obi_gnt = 1'b0;
    obi_gntpar = 1'b1;
    obi_rvalid = 1'b0;
    obi_rvalidpar = 1'b1;
    obi_rdata = '0;
    obi_err = 1'b0;
    obi_rchk = '0;
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_n = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n = 1'b1;
    clear_model();
    fault_seen = 1'b0;
    bit_check("obi_req after reset", 1'b0, obi_req);
    bit_check("obi_reqpar after reset", 1'b1, obi_reqpar);
    bit_check("resp_valid after reset", 1'b0, resp_valid);
    bit_check("alert_major after reset", 1'b0, alert_major);
  endtask

  task automatic configure_phase(input string name, input logic enable, input int rchk,
                                 input int rvp, input int gp);
    test_name = name;
    integrity_enable = enable;
    rchk_rate = rchk;
    rvp_rate = rvp;
    gp_rate = gp;
  endtask

  task automatic drive_cycle(input int k);
    logic                     drain;
    logic [31:0]              rnd;
    obi_integrity_pkg::rchk_t mask;
    logic                     par_fault;
    logic                     ie;
    drain = (k >= PHASE_CYCLES - DRAIN_CYCLES);
    // Memory grants at random but never past the tracker depth
    obi_gnt = m_req && (q_store.size() < obi_integrity_pkg::OUTSTANDING_DEPTH)
              && (drain || one_in(2));
    obi_gntpar = ~obi_gnt;
    if (gp_rate != 0 && one_in(gp_rate)) begin
      obi_gntpar = obi_gnt;
      note_fault();
    end
    // In-order responses a random number of cycles after the grant
    if (q_store.size() != 0 && (drain || one_in(3))) begin
      rnd = $random(seed);
      obi_rvalid = 1'b1;
      obi_rdata = rnd;
      obi_err = one_in(8);
      mask = '0;
      if (rchk_rate != 0 && one_in(rchk_rate)) begin
        rnd = $random(seed);
        mask = (rnd[4:0] == 5'd0) ? 5'h10 : rnd[4:0];
      end
      obi_rchk = rchk_expected(obi_err, obi_rdata) ^ mask;
      obi_rvalidpar = 1'b0;
      if (rvp_rate != 0 && one_in(rvp_rate)) begin
        obi_rvalidpar = 1'b1;
      end
      par_fault = (obi_rvalidpar == obi_rvalid) || q_gnt_fault[0];
      ie = integrity_err_expected(q_store[0], q_integrity[0], integrity_enable, mask, par_fault);
      push_expected(cycle + 3, obi_rdata, obi_err, ie);
      if (ie) begin
        note_fault();
      end
    end else begin
      obi_rvalid = 1'b0;
      obi_rvalidpar = 1'b1;
    end
    // Core waits for a free bus slot
    core_req = (!m_req || obi_gnt) && !drain && one_in(2);
    rnd = $random(seed);
    core_addr = rnd;
    rnd = $random(seed);
    core_wdata = rnd;
    rnd = $random(seed);
    core_be = rnd[3:0];
    core_we = rnd[4];
    core_prot = rnd[7:5];
    core_memtype = rnd[9:8];
    core_dbg = rnd[10];
    core_integrity = (rnd[13:11] != 3'd0);
  endtask

  // Effect of the clock edge, using the inputs that were driven
  task automatic step_model();
    if (obi_rvalid) begin
      void'(q_store.pop_front());
      void'(q_integrity.pop_front());
      void'(q_gnt_fault.pop_front());
    end
    if (m_req && obi_gnt) begin
      q_store.push_back(m_we);
      q_integrity.push_back(m_integrity);
      q_gnt_fault.push_back(obi_gntpar == obi_gnt);
    end
    if (!m_req || obi_gnt) begin
      m_req = core_req;
      if (core_req) begin
        m_addr = core_addr;
        m_we = core_we;
        m_be = core_be;
        m_wdata = core_wdata;
        m_prot = core_prot;
        m_memtype = core_memtype;
        m_dbg = core_dbg;
        m_integrity = core_integrity;
      end
    end
  endtask

  task automatic check_outputs();
    bit_check("obi_req", m_req, obi_req);
    bit_check("obi_reqpar", ~m_req, obi_reqpar);
    if (m_req) begin
      achk_check("obi_achk",
                 achk_expected(m_addr, m_we, m_be, m_wdata, m_prot, m_memtype, m_dbg), obi_achk);
      data_check("obi_addr", m_addr, obi_addr);
      data_check("obi_wdata", m_wdata, obi_wdata);
      bit_check("obi_we", m_we, obi_we);
      be_check("obi_be", m_be, obi_be);
      prot_check("obi_prot", m_prot, obi_prot);
      memtype_check("obi_memtype", m_memtype, obi_memtype);
      bit_check("obi_dbg", m_dbg, obi_dbg);
    end
    if (resp_valid) begin
      if (exp_due.size() == 0) begin
        other_errors++;
        $display("Response at cycle %0d in %s while none was expected", cycle, test_name);
      end else begin
        if (exp_due[0] != cycle) begin
          other_errors++;
          $display("Response at cycle %0d, expected at cycle %0d", cycle, exp_due[0]);
        end
        data_check("resp_rdata", exp_rdata[0], resp_rdata);
        bit_check("resp_err", exp_err[0], resp_err);
        bit_check("resp_integrity_err", exp_ie[0], resp_integrity_err);
        drop_expected();
      end
    end else if (exp_due.size() != 0 && exp_due[0] <= cycle) begin
      other_errors++;
      $display("Response due at cycle %0d never appeared in %s", exp_due[0], test_name);
      drop_expected();
    end
    if (!fault_seen) begin
      bit_check("alert_major without fault", 1'b0, alert_major);
    end else if (cycle >= alert_deadline) begin
      bit_check("alert_major after fault", 1'b1, alert_major);
    end
  endtask

  task automatic run_phase(input int phase);
    case (phase)
      0:       configure_phase("clean", 1'b1, 0, 0, 0);
      1:       configure_phase("rchk_corrupt", 1'b1, 3, 0, 0);
      2:       configure_phase("integrity_off", 1'b0, 2, 0, 0);
      default: configure_phase("parity_fault", 1'b0, 0, 15, 20);
    endcase
    for (int k = 0; k < PHASE_CYCLES; k++) begin
      drive_cycle(k);
      @(negedge clk_i);
      cycle++;
      step_model();
      check_outputs();
    end
    if (exp_due.size() != 0 || q_store.size() != 0 || m_req) begin
      other_errors++;
      $display("Phase %s ended with requests or responses still outstanding", test_name);
    end
  endtask

  initial begin
    seed = 32'h19d2e47f;
    cycle = 0;
    value_errors = 0;
    other_errors = 0;
    test_name = "reset";
    clk_i = 1'b0;
    rst_n = 1'b0;
    integrity_enable = 1'b0;
    rchk_rate = 0;
    rvp_rate = 0;
    gp_rate = 0;
    fault_seen = 1'b0;
    alert_deadline = 0;
    drive_idle();
    for (int phase = 0; phase < NUM_PHASES; phase++) begin
      apply_reset();
      run_phase(phase);
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/obi_integrity_top.sv ====
/*
  Integrity unit for one data bus. Request stage on one side, tracker in
  the middle, three response stages ending in the major alert.
*/
`timescale 1ns/10ps

module obi_integrity_top (
  input  logic                        clk_i,
  input  logic                        rst_n,
  input  logic                        integrity_enable,
  input  logic                        core_req,
  input  obi_integrity_pkg::addr_t    core_addr,
  input  logic                        core_we,
  input  obi_integrity_pkg::be_t      core_be,
  input  obi_integrity_pkg::data_t    core_wdata,
  input  obi_integrity_pkg::prot_t    core_prot,
  input  obi_integrity_pkg::memtype_t core_memtype,
  input  logic                        core_dbg,
  input  logic                        core_integrity,
  input  logic                        obi_gnt,
  input  logic                        obi_gntpar,
  input  logic                        obi_rvalid,
  input  logic                        obi_rvalidpar,
  input  obi_integrity_pkg::data_t    obi_rdata,
  input  logic                        obi_err,
  input  obi_integrity_pkg::rchk_t    obi_rchk,
  output logic                        obi_req,
  output logic                        obi_reqpar,
  output obi_integrity_pkg::addr_t    obi_addr,
  output logic                        obi_we,
  output obi_integrity_pkg::be_t      obi_be,
  output obi_integrity_pkg::data_t    obi_wdata,
  output obi_integrity_pkg::prot_t    obi_prot,
  output obi_integrity_pkg::memtype_t obi_memtype,
  output logic                        obi_dbg,
  output obi_integrity_pkg::achk_t    obi_achk,
  output logic                        resp_valid,
  output obi_integrity_pkg::data_t    resp_rdata,
  output logic                        resp_err,
  output logic                        resp_integrity_err,
  output logic                        alert_major
);

  logic obi_integrity;
  logic pop;
  logic head_valid;
  logic head_store;
  logic head_integrity;
  logic head_gnt_fault;
  logic gnt_fault_pulse;
  logic cap_valid;
  obi_integrity_pkg::data_t cap_rdata;
  logic cap_err;
  obi_integrity_pkg::rchk_t cap_rchk;
  logic cap_store;
  logic cap_integrity;
  logic cap_par_fault;
  logic chk_valid;
  obi_integrity_pkg::data_t chk_rdata;
  logic chk_err;
  logic chk_integrity_err;
  logic chk_par_fault;

  achk_gen u_achk_gen (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .core_req       (core_req),
    .core_addr      (core_addr),
    .core_we        (core_we),
    .core_be        (core_be),
    .core_wdata     (core_wdata),
    .core_prot      (core_prot),
    .core_memtype   (core_memtype),
    .core_dbg       (core_dbg),
    .core_integrity (core_integrity),
    .obi_gnt        (obi_gnt),
    .obi_req        (obi_req),
    .obi_reqpar     (obi_reqpar),
    .obi_addr       (obi_addr),
    .obi_we         (obi_we),
    .obi_be         (obi_be),
    .obi_wdata      (obi_wdata),
    .obi_prot       (obi_prot),
    .obi_memtype    (obi_memtype),
    .obi_dbg        (obi_dbg),
    .obi_achk       (obi_achk),
    .obi_integrity  (obi_integrity)
  );

  req_tracker u_req_tracker (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .obi_req         (obi_req),
    .obi_we          (obi_we),
    .obi_integrity   (obi_integrity),
    .obi_gnt         (obi_gnt),
    .obi_gntpar      (obi_gntpar),
    .pop             (pop),
    .head_valid      (head_valid),
    .head_store      (head_store),
    .head_integrity  (head_integrity),
    .head_gnt_fault  (head_gnt_fault),
    .gnt_fault_pulse (gnt_fault_pulse)
  );

  resp_capture u_resp_capture (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .obi_rvalid     (obi_rvalid),
    .obi_rvalidpar  (obi_rvalidpar),
    .obi_rdata      (obi_rdata),
    .obi_err        (obi_err),
    .obi_rchk       (obi_rchk),
    .head_valid     (head_valid),
    .head_store     (head_store),
    .head_integrity (head_integrity),
    .head_gnt_fault (head_gnt_fault),
    .pop            (pop),
    .cap_valid      (cap_valid),
    .cap_rdata      (cap_rdata),
    .cap_err        (cap_err),
    .cap_rchk       (cap_rchk),
    .cap_store      (cap_store),
    .cap_integrity  (cap_integrity),
    .cap_par_fault  (cap_par_fault)
  );

  rchk_check u_rchk_check (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .integrity_enable  (integrity_enable),
    .cap_valid         (cap_valid),
    .cap_rdata         (cap_rdata),
    .cap_err           (cap_err),
    .cap_rchk          (cap_rchk),
    .cap_store         (cap_store),
    .cap_integrity     (cap_integrity),
    .cap_par_fault     (cap_par_fault),
    .chk_valid         (chk_valid),
    .chk_rdata         (chk_rdata),
    .chk_err           (chk_err),
    .chk_integrity_err (chk_integrity_err),
    .chk_par_fault     (chk_par_fault)
  );

  alert_ctrl u_alert_ctrl (
    .clk_i              (clk_i),
    .rst_n              (rst_n),
    .chk_valid          (chk_valid),
    .chk_rdata          (chk_rdata),
    .chk_err            (chk_err),
    .chk_integrity_err  (chk_integrity_err),
    .chk_par_fault      (chk_par_fault),
    .gnt_fault_pulse    (gnt_fault_pulse),
    .resp_valid         (resp_valid),
    .resp_rdata         (resp_rdata),
    .resp_err           (resp_err),
    .resp_integrity_err (resp_integrity_err),
    .alert_major        (alert_major)
  );

endmodule

// ==== src/alert_ctrl.sv ====
/*
  Last response stage. Drives the response outputs and holds the major
  alert once any integrity error or grant parity fault is seen.
*/
`timescale 1ns/10ps

module alert_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  logic                     chk_valid,
  input  obi_integrity_pkg::data_t chk_rdata,
  input  logic                     chk_err,
  input  logic                     chk_integrity_err,
  input  logic                     chk_par_fault,
  input  logic                     gnt_fault_pulse,
  output logic                     resp_valid,
  output obi_integrity_pkg::data_t resp_rdata,
  output logic                     resp_err,
  output logic                     resp_integrity_err,
  output logic                     alert_major
);

  logic resp_fault;
  logic alert_set;

  // Parity faults alert regardless of the checksum gate
  assign resp_fault = chk_valid && (chk_integrity_err || chk_par_fault);
  assign alert_set = resp_fault || gnt_fault_pulse;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      resp_valid         <= 1'b0;
      resp_integrity_err <= 1'b0;
      alert_major        <= 1'b0;
    end else begin
      resp_valid         <= chk_valid;
      resp_integrity_err <= resp_fault;
      if (alert_set) begin
        alert_major <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (chk_valid) begin
      resp_rdata <= chk_rdata;
      resp_err   <= chk_err;
    end
  end

  // Sticky until reset
  a_alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_n)
    alert_major |=> alert_major);

endmodule

// ==== src/rchk_check.sv ====
/*
  Second response stage. Recomputes the response checksum and compares it
  with the received one. Stores compare only the error bit. A mismatch counts
  only with integrity enabled and requested; parity faults always count.
*/
`timescale 1ns/10ps

module rchk_check (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  logic                     integrity_enable,
  input  logic                     cap_valid,
  input  obi_integrity_pkg::data_t cap_rdata,
  input  logic                     cap_err,
  input  obi_integrity_pkg::rchk_t cap_rchk,
  input  logic                     cap_store,
  input  logic                     cap_integrity,
  input  logic                     cap_par_fault,
  output logic                     chk_valid,
  output obi_integrity_pkg::data_t chk_rdata,
  output logic                     chk_err,
  output logic                     chk_integrity_err,
  output logic                     chk_par_fault
);

  obi_integrity_pkg::rchk_t rchk_calc;
  logic err_bit_mismatch;
  logic all_mismatch;
  logic mismatch;
  logic counted;

  assign rchk_calc = obi_integrity_pkg::f_rchk(cap_err, cap_rdata);

  assign err_bit_mismatch = cap_rchk[obi_integrity_pkg::RCHK_ERR_BIT] !=
                            rchk_calc[obi_integrity_pkg::RCHK_ERR_BIT];
  assign all_mismatch = (cap_rchk != rchk_calc);

  // Store responses carry no read data to protect
  assign mismatch = cap_store ? err_bit_mismatch : all_mismatch;
  assign counted = mismatch && integrity_enable && cap_integrity;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      chk_valid <= 1'b0;
    end else begin
      chk_valid <= cap_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_valid) begin
      chk_rdata         <= cap_rdata;
      chk_err           <= cap_err;
      chk_integrity_err <= counted || cap_par_fault;
      chk_par_fault     <= cap_par_fault;
    end
  end

endmodule

// ==== src/resp_capture.sv ====
/*
  First response stage. Pops the tracker head on each rvalid and registers
  the response with the head entry. Parity faults and unexpected responses
  are folded into one flag.
*/
`timescale 1ns/10ps

module resp_capture (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  logic                     obi_rvalid,
  input  logic                     obi_rvalidpar,
  input  obi_integrity_pkg::data_t obi_rdata,
  input  logic                     obi_err,
  input  obi_integrity_pkg::rchk_t obi_rchk,
  input  logic                     head_valid,
  input  logic                     head_store,
  input  logic                     head_integrity,
  input  logic                     head_gnt_fault,
  output logic                     pop,
  output logic                     cap_valid,
  output obi_integrity_pkg::data_t cap_rdata,
  output logic                     cap_err,
  output obi_integrity_pkg::rchk_t cap_rchk,
  output logic                     cap_store,
  output logic                     cap_integrity,
  output logic                     cap_par_fault
);

  logic rvalid_fault;
  logic unexpected;

  assign pop = obi_rvalid;
  assign rvalid_fault = (obi_rvalidpar == obi_rvalid);
  assign unexpected = obi_rvalid && !head_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= obi_rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_rvalid) begin
      cap_rdata     <= obi_rdata;
      cap_err       <= obi_err;
      cap_rchk      <= obi_rchk;
      cap_store     <= head_store;
      cap_integrity <= head_integrity;
      cap_par_fault <= rvalid_fault || head_gnt_fault || unexpected;
    end
  end

endmodule

// ==== src/req_tracker.sv ====
/*
  Queue of granted requests still waiting for a response. Each entry keeps
  the store flag, the integrity flag and any grant parity fault seen at
  grant time. The head entry is read by the response capture stage.
*/
`timescale 1ns/10ps

module req_tracker (
  input  logic clk_i,
  input  logic rst_n,
  input  logic obi_req,
  input  logic obi_we,
  input  logic obi_integrity,
  input  logic obi_gnt,
  input  logic obi_gntpar,
  input  logic pop,
  output logic head_valid,
  output logic head_store,
  output logic head_integrity,
  output logic head_gnt_fault,
  output logic gnt_fault_pulse
);

  logic [obi_integrity_pkg::PTR_W-1:0] wr_ptr;
  logic [obi_integrity_pkg::PTR_W-1:0] rd_ptr;
  logic [obi_integrity_pkg::PTR_W:0]   count;
  logic ent_store     [obi_integrity_pkg::OUTSTANDING_DEPTH];
  logic ent_integrity [obi_integrity_pkg::OUTSTANDING_DEPTH];
  logic ent_gnt_fault [obi_integrity_pkg::OUTSTANDING_DEPTH];
  logic push;
  logic pop_ok;
  logic gnt_fault;
  logic full;

  assign push = obi_req && obi_gnt;
  // Grant parity must be the inverse of grant
  assign gnt_fault = (obi_gntpar == obi_gnt);

  // Pop on an empty queue is an unexpected response, handled downstream
  assign pop_ok = pop && head_valid;

  assign head_valid = (count != '0);
  assign full = (count == (obi_integrity_pkg::PTR_W + 1)'(obi_integrity_pkg::OUTSTANDING_DEPTH));

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      ent_store[wr_ptr]     <= obi_we;
      ent_integrity[wr_ptr] <= obi_integrity;
      ent_gnt_fault[wr_ptr] <= gnt_fault;
    end
  end

  assign head_store     = ent_store[rd_ptr];
  assign head_integrity = ent_integrity[rd_ptr];
  assign head_gnt_fault = ent_gnt_fault[rd_ptr];

  // Fault pulse to the alert, also without a request on the bus
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      gnt_fault_pulse <= 1'b0;
    end else begin
      gnt_fault_pulse <= gnt_fault;
    end
  end

  // A full queue only accepts a grant when the head leaves in the same cycle
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n)
    push && full |-> pop_ok);

endmodule

// ==== src/achk_gen.sv ====
/*
  Request stage. Registers a processor request, holds it on the bus until
  granted and adds the request parity bit and the address phase checksum.
*/
`timescale 1ns/10ps

module achk_gen (
  input  logic                        clk_i,
  input  logic                        rst_n,
  input  logic                        core_req,
  input  obi_integrity_pkg::addr_t    core_addr,
  input  logic                        core_we,
  input  obi_integrity_pkg::be_t      core_be,
  input  obi_integrity_pkg::data_t    core_wdata,
  input  obi_integrity_pkg::prot_t    core_prot,
  input  obi_integrity_pkg::memtype_t core_memtype,
  input  logic                        core_dbg,
  input  logic                        core_integrity,
  input  logic                        obi_gnt,
  output logic                        obi_req,
  output logic                        obi_reqpar,
  output obi_integrity_pkg::addr_t    obi_addr,
  output logic                        obi_we,
  output obi_integrity_pkg::be_t      obi_be,
  output obi_integrity_pkg::data_t    obi_wdata,
  output obi_integrity_pkg::prot_t    obi_prot,
  output obi_integrity_pkg::memtype_t obi_memtype,
  output logic                        obi_dbg,
  output obi_integrity_pkg::achk_t    obi_achk,
  output logic                        obi_integrity
);

  logic slot_free;

  // Bus slot opens when idle or when the held request is granted
  assign slot_free = !obi_req || obi_gnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      obi_req <= 1'b0;
    end else if (slot_free) begin
      obi_req <= core_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_free && core_req) begin
      obi_addr      <= core_addr;
      obi_we        <= core_we;
      obi_be        <= core_be;
      obi_wdata     <= core_wdata;
      obi_prot      <= core_prot;
      obi_memtype   <= core_memtype;
      obi_dbg       <= core_dbg;
      obi_integrity <= core_integrity;
    end
  end

  assign obi_reqpar = ~obi_req;
  assign obi_achk = obi_integrity_pkg::f_achk(obi_wdata, obi_dbg, obi_be, obi_we,
                                              obi_prot, obi_memtype, obi_addr);

  // An ungranted request keeps its address phase unchanged
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n)
    obi_req && !obi_gnt |=> obi_req && $stable(obi_addr) && $stable(obi_achk));

endmodule

// ==== src/obi_integrity_pkg.sv ====
/*
  Shared widths, types, queue depth and checksum rules for the data bus
  integrity unit. Modules refer to these by scoped name.
*/
package obi_integrity_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [2:0]  prot_t;
  typedef logic [1:0]  memtype_t;
  typedef logic [12:0] achk_t;
  typedef logic [4:0]  rchk_t;

  // Granted requests that may wait for a response
  localparam int OUTSTANDING_DEPTH = 4;
  localparam int PTR_W = 2;

  // Only this rchk bit is compared on a store response
  localparam int RCHK_ERR_BIT = 4;

  // Fields not carried by this bus, fixed at zero
  localparam logic [5:0] ATOP_VALUE = 6'b00_0000;
  localparam logic [7:0] MID_VALUE = 8'h00;
  localparam logic EXOKAY_VALUE = 1'b0;

  // Address phase checksum over the held request fields
  function automatic achk_t f_achk(
    input data_t    wdata,
    input logic     dbg,
    input be_t      be,
    input logic     we,
    input prot_t    prot,
    input memtype_t memtype,
    input addr_t    addr
  );
    return {^wdata[31:24], ^wdata[23:16], ^wdata[15:8], ^wdata[7:0],
            ~^dbg,
            ^ATOP_VALUE,
            ^MID_VALUE,
            ~^{be, we},
            ~^{prot, memtype},
            ^addr[31:24], ^addr[23:16], ^addr[15:8], ^addr[7:0]};
  endfunction

  // Response checksum, top bit covers err and exokay
  function automatic rchk_t f_rchk(
    input logic  err,
    input data_t rdata
  );
    return {^{err, EXOKAY_VALUE},
            ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage
